// File: design/finv_pkg.sv
`default_nettype none

package finv_pkg;

   typedef logic [7:0]  exp_t;
   typedef logic [22:0] frac_t;
   typedef logic [23:0] mant_t;
   // 26 fraction bits, no integer part
   typedef logic [25:0] recip_t;

   typedef struct packed {
      logic  sign;
      exp_t  exponent;
      frac_t fraction;
   } float_t;

   localparam int SEED_BITS  = 8;
   localparam int PIPE_DEPTH = 3;

   localparam exp_t EXP_MAX       = 8'd255;
   localparam exp_t EXP_DENORM_HI = 8'd254;
   localparam exp_t EXP_DENORM_LO = 8'd253;

   localparam logic [1:0] ADR_OPERAND = 2'd0;
   localparam logic [1:0] ADR_RESULT  = 2'd1;
   localparam logic [1:0] ADR_STATUS  = 2'd2;

   typedef enum logic [2:0] {
      CLS_NORMAL,
      CLS_POW2,
      CLS_NAN,
      CLS_INF,
      CLS_ZERO
   } class_e;

   typedef enum logic [1:0] {
      SH_NORMAL,
      SH_DENORM1,
      SH_DENORM2
   } shift_e;

   typedef enum logic [1:0] {
      WB_IDLE,
      WB_BUSY,
      WB_ACK
   } wb_state_e;

   // 2^26 / (1 + (i + 0.5) / 2^SEED_BITS) rounded to nearest
   function automatic recip_t seed_value(input int unsigned i);
      longint unsigned num;
      longint unsigned den;
      num = 64'd1 << (26 + SEED_BITS + 1);
      den = (64'd1 << (SEED_BITS + 1)) + 2 * longint'(i) + 1;
      return recip_t'((num + den / 2) / den);
   endfunction

endpackage

`default_nettype wire

// File: design/finv_operand_if.sv
`default_nettype none

// unpacked operand with the hidden one already in the mantissa
interface finv_operand_if;

   logic              valid;
   logic              sign;
   finv_pkg::exp_t    exponent;
   finv_pkg::mant_t   mantissa;

   modport src (
      output valid,
      output sign,
      output exponent,
      output mantissa
   );

   modport sink (
      input valid,
      input sign,
      input exponent,
      input mantissa
   );

endinterface

`default_nettype wire

// File: design/recip_mantissa.sv
`default_nettype none

module recip_mantissa (
   input  logic                 clk,
   input  logic                 rst_n,
   finv_operand_if.sink         op,
   output finv_pkg::recip_t     est,
   output logic                 est_valid
);

   localparam int SEED_ENTRIES = 2 ** finv_pkg::SEED_BITS;

   finv_pkg::recip_t seed_rom [SEED_ENTRIES];

   logic [finv_pkg::SEED_BITS-1:0] seed_idx;

   logic             s1_valid;
   finv_pkg::recip_t s1_seed;
   finv_pkg::mant_t  s1_mant;

   logic             s2_valid;
   finv_pkg::recip_t s2_x;
   finv_pkg::mant_t  s2_mant;

   // one step of x * (2 - a*x) on a product with 75 fraction bits
   function automatic finv_pkg::recip_t newton_step(
      input finv_pkg::mant_t  a,
      input finv_pkg::recip_t x
   );
      logic [74:0] k;
      logic [75:0] p;
      logic        round_up;
      k = 75'(a) * 75'(x) * 75'(x);
      p = {x, 50'b0} - {1'b0, k};
      // round to nearest even on bit 48
      round_up = p[48] && ((|p[47:0]) || p[49]);
      return p[74:49] + finv_pkg::recip_t'(round_up);
   endfunction

   // table is built at elaboration
   for (genvar g = 0; g < SEED_ENTRIES; g++) begin : g_seed
      assign seed_rom[g] = finv_pkg::seed_value(g);
   end

   // top fraction bits select the seed
   assign seed_idx = op.mantissa[22 -: finv_pkg::SEED_BITS];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         est_valid <= 1'b0;
      end else begin
         s1_valid  <= op.valid;
         s2_valid  <= s1_valid;
         est_valid <= s2_valid;
      end
   end

   // stage 1 seed lookup
   always_ff @(posedge clk) begin
      s1_seed <= seed_rom[seed_idx];
      s1_mant <= op.mantissa;
   end

   // stage 2 first iteration
   always_ff @(posedge clk) begin
      s2_x    <= newton_step(s1_mant, s1_seed);
      s2_mant <= s1_mant;
   end

   // stage 3 second iteration
   always_ff @(posedge clk) begin
      est <= newton_step(s2_mant, s2_x);
   end

endmodule

`default_nettype wire

// File: design/recip_exponent.sv
`default_nettype none

module recip_exponent (
   input  logic                 clk,
   input  logic                 rst_n,
   finv_operand_if.sink         op,
   output finv_pkg::class_e     cls,
   output finv_pkg::shift_e     shift,
   output finv_pkg::exp_t       exp_out,
   output logic                 sign_out,
   output finv_pkg::frac_t      frac_in
);

   typedef struct packed {
      finv_pkg::class_e cls;
      finv_pkg::shift_e shift;
      finv_pkg::exp_t   exp_res;
      logic             sign;
      finv_pkg::frac_t  frac;
   } info_t;

   finv_pkg::exp_t  e;
   finv_pkg::frac_t frac;
   logic            frac_zero;
   logic            e_hi;
   info_t           info_d;
   info_t           line_q [finv_pkg::PIPE_DEPTH];

   assign e         = op.exponent;
   assign frac      = op.mantissa[22:0];
   assign frac_zero = (frac == '0);
   assign e_hi      = (e == finv_pkg::EXP_DENORM_HI);

   always_comb begin
      info_d.sign = op.sign;
      info_d.frac = frac;

      if (e_hi) begin
         info_d.shift = finv_pkg::SH_DENORM2;
      end else if (e == finv_pkg::EXP_DENORM_LO) begin
         info_d.shift = finv_pkg::SH_DENORM1;
      end else begin
         info_d.shift = finv_pkg::SH_NORMAL;
      end

      // denormal inputs fall through as normals
      if (e == finv_pkg::EXP_MAX) begin
         info_d.cls = frac_zero ? finv_pkg::CLS_INF : finv_pkg::CLS_NAN;
      end else if (e == '0 && frac_zero) begin
         info_d.cls = finv_pkg::CLS_ZERO;
      end else if (frac_zero) begin
         info_d.cls = finv_pkg::CLS_POW2;
      end else begin
         info_d.cls = finv_pkg::CLS_NORMAL;
      end

      // 1/2^k needs one more than a general mantissa
      if (e_hi) begin
         info_d.exp_res = '0;
      end else if (frac_zero) begin
         info_d.exp_res = finv_pkg::EXP_DENORM_HI - e;
      end else begin
         info_d.exp_res = finv_pkg::EXP_DENORM_LO - e;
      end
   end

   // matches the mantissa path latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < finv_pkg::PIPE_DEPTH; i++) begin
            line_q[i] <= '0;
         end
      end else begin
         if (op.valid) begin
            line_q[0] <= info_d;
         end
         for (int i = 1; i < finv_pkg::PIPE_DEPTH; i++) begin
            line_q[i] <= line_q[i-1];
         end
      end
   end

   assign cls      = line_q[finv_pkg::PIPE_DEPTH-1].cls;
   assign shift    = line_q[finv_pkg::PIPE_DEPTH-1].shift;
   assign exp_out  = line_q[finv_pkg::PIPE_DEPTH-1].exp_res;
   assign sign_out = line_q[finv_pkg::PIPE_DEPTH-1].sign;
   assign frac_in  = line_q[finv_pkg::PIPE_DEPTH-1].frac;

endmodule

`default_nettype wire

// File: design/recip_pack.sv
`default_nettype none

module recip_pack (
   input  finv_pkg::recip_t     est,
   input  finv_pkg::class_e     cls,
   input  finv_pkg::shift_e     shift,
   input  finv_pkg::exp_t       exp_out,
   input  logic                 sign_out,
   input  finv_pkg::frac_t      frac_in,
   output finv_pkg::float_t     result,
   output logic                 exception
);

   // bit 23 is the carry out of rounding
   logic [23:0] rounded;

   always_comb begin
      case (shift)
         finv_pkg::SH_DENORM2: rounded = {2'b00, est[25:4]} + 24'(est[3]);
         finv_pkg::SH_DENORM1: rounded = {1'b0, est[25:3]} + 24'(est[2]);
         // est[25] is the hidden one here
         default:              rounded = {1'b0, est[24:2]} + 24'(est[1]);
      endcase
   end

   always_comb begin
      result.sign     = sign_out;
      result.exponent = exp_out + finv_pkg::exp_t'(rounded[23]);
      result.fraction = rounded[22:0];

      case (cls)
         finv_pkg::CLS_NAN: begin
            // quiet bit forced, payload kept
            result.exponent = finv_pkg::EXP_MAX;
            result.fraction = {1'b1, frac_in[21:0]};
         end
         finv_pkg::CLS_INF: begin
            result.exponent = '0;
            result.fraction = '0;
         end
         finv_pkg::CLS_ZERO: begin
            result.exponent = finv_pkg::EXP_MAX;
            result.fraction = '0;
         end
         finv_pkg::CLS_POW2: begin
            result.exponent = exp_out;
            if (shift == finv_pkg::SH_DENORM2) begin
               result.fraction = 23'h400000;
            end else begin
               result.fraction = '0;
            end
         end
         default: begin
         end
      endcase
   end

   assign exception = (cls == finv_pkg::CLS_NAN);

endmodule

`default_nettype wire

// File: design/finv_wb.sv
`default_nettype none

module finv_wb (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cyc,
   input  logic        stb,
   input  logic        we,
   input  logic [1:0]  adr,
   input  logic [31:0] dat_w,
   output logic [31:0] dat_r,
   output logic        ack
);

   finv_pkg::wb_state_e state;

   finv_pkg::float_t operand_q;
   logic             op_valid_q;
   finv_pkg::float_t result_q;
   logic             exc_q;
   logic             start_op;
   logic [31:0]      read_data;

   finv_pkg::recip_t est;
   logic             est_valid;
   finv_pkg::class_e cls;
   finv_pkg::shift_e shift;
   finv_pkg::exp_t   exp_out;
   logic             sign_out;
   finv_pkg::frac_t  frac_in;
   finv_pkg::float_t pack_result;
   logic             pack_exc;

   finv_operand_if u_op_if ();

   assign u_op_if.valid    = op_valid_q;
   assign u_op_if.sign     = operand_q.sign;
   assign u_op_if.exponent = operand_q.exponent;
   assign u_op_if.mantissa = {1'b1, operand_q.fraction};

   recip_mantissa u_mantissa (
      .clk       (clk),
      .rst_n     (rst_n),
      .op        (u_op_if.sink),
      .est       (est),
      .est_valid (est_valid)
   );

   recip_exponent u_exponent (
      .clk      (clk),
      .rst_n    (rst_n),
      .op       (u_op_if.sink),
      .cls      (cls),
      .shift    (shift),
      .exp_out  (exp_out),
      .sign_out (sign_out),
      .frac_in  (frac_in)
   );

   recip_pack u_pack (
      .est       (est),
      .cls       (cls),
      .shift     (shift),
      .exp_out   (exp_out),
      .sign_out  (sign_out),
      .frac_in   (frac_in),
      .result    (pack_result),
      .exception (pack_exc)
   );

   assign start_op = (state == finv_pkg::WB_IDLE) && cyc && stb && we
                     && (adr == finv_pkg::ADR_OPERAND);

   always_comb begin
      case (adr)
         finv_pkg::ADR_OPERAND: read_data = operand_q;
         finv_pkg::ADR_RESULT:  read_data = result_q;
         finv_pkg::ADR_STATUS:  read_data = {31'b0, exc_q};
         default:               read_data = '0;
      endcase
   end

   // write ack waits for the pipeline to drain
   assign ack = (state == finv_pkg::WB_ACK) || (state == finv_pkg::WB_BUSY && est_valid);

   always_ff @(posedge clk) begin
      if (start_op) begin
         operand_q <= dat_w;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= finv_pkg::WB_IDLE;
         op_valid_q <= 1'b0;
         dat_r      <= '0;
         result_q   <= '0;
         exc_q      <= 1'b0;
      end else begin
         op_valid_q <= start_op;
         case (state)
            finv_pkg::WB_IDLE: begin
               if (start_op) begin
                  state <= finv_pkg::WB_BUSY;
               end else if (cyc && stb) begin
                  // other writes are dropped
                  state <= finv_pkg::WB_ACK;
                  if (!we) begin
                     dat_r <= read_data;
                  end
               end
            end
            finv_pkg::WB_BUSY: begin
               if (est_valid) begin
                  result_q <= pack_result;
                  exc_q    <= pack_exc;
                  state    <= finv_pkg::WB_IDLE;
               end
            end
            finv_pkg::WB_ACK: state <= finv_pkg::WB_IDLE;
            default:          state <= finv_pkg::WB_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`default_nettype none

module tb_clock (
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 10;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb/tb_finv.sv
`default_nettype none

module tb_finv;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_RANDOM      = 200;
   // bus transfers over the whole run
   localparam int NUM_OPS         = 2 * NUM_RANDOM + 60;
   localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + 200;
   localparam int ACK_LIMIT       = 20;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   logic        clk;
   logic        rst_n;
   logic        cyc;
   logic        stb;
   logic        we;
   logic [1:0]  adr;
   logic [31:0] dat_w;
   logic [31:0] dat_r;
   logic        ack;
   logic [31:0] lfsr_state = 32'h1141;

   tb_clock u_clock (.clk(clk), .rst_n(rst_n));

   finv_wb u_dut (
      .clk   (clk),
      .rst_n (rst_n),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_float(input string name, input finv_pkg::float_t got,
                              input finv_pkg::float_t exp, input int tol);
      longint diff;
      diff = longint'(got[30:0]) - longint'(exp[30:0]);
      if ($isunknown(got) || got.sign !== exp.sign || diff > tol || diff < -tol) begin
         report_failure($sformatf("Mismatch at %0t: %s got %08h expected %08h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      if (got != exp) begin
         report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                  $time, name, got, exp));
      end
   endtask

   function automatic real pow2(input int n);
      real r;
      r = 1.0;
      for (int i = 0; i < (n < 0 ? -n : n); i++) begin
         r = (n < 0) ? r / 2.0 : r * 2.0;
      end
      return r;
   endfunction

   function automatic longint round_even(input real t);
      longint ip;
      real    rem;
      ip  = longint'($floor(t));
      rem = t - ip;
      if (rem > 0.5 || (rem == 0.5 && ip[0])) begin
         ip++;
      end
      return ip;
   endfunction

   // 1/x rounded to nearest single with denormal results at 2^-149 resolution
   function automatic finv_pkg::float_t ref_recip(input finv_pkg::float_t x);
      finv_pkg::float_t y;
      real              r;
      real              m;
      int               ex;
      longint           mag;
      y.sign = x.sign;
      if (x.exponent == 8'hff && x.fraction != '0) begin
         y[30:0] = {8'hff, 1'b1, x.fraction[21:0]};
      end else if (x.exponent == 8'hff) begin
         y[30:0] = '0;
      end else if (x[30:0] == '0) begin
         y[30:0] = {8'hff, 23'h0};
      end else begin
         r  = 1.0 / ((1.0 + x.fraction / 8388608.0) * pow2(int'(x.exponent) - 127));
         m  = r;
         ex = 0;
         while (m >= 2.0) begin
            m = m / 2.0;
            ex++;
         end
         while (m < 1.0) begin
            m = m * 2.0;
            ex--;
         end
         if (ex + 127 >= 1) begin
            mag = longint'(ex + 127) * 8388608 + round_even(m * 8388608.0) - 8388608;
         end else begin
            mag = round_even(r * pow2(149));
         end
         y[30:0] = mag[30:0];
      end
      return y;
   endfunction

   // galois lfsr stepped once per bit
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   // starts 1 ns after a rising edge and returns there after ack
   task automatic transfer(input logic write, input logic [1:0] a, input logic [31:0] wdata,
                           output logic [31:0] rdata, output int cycles);
      int n;
      n     = 0;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = a;
      dat_w = wdata;
      do begin
         @(negedge clk);
         n++;
         if (n > ACK_LIMIT) begin
            report_failure($sformatf("no ack within %0d cycles at address %0d", ACK_LIMIT, a));
         end
      end while (ack !== 1'b1);
      rdata = dat_r;
      @(posedge clk);
      #1;
      cyc    = 1'b0;
      stb    = 1'b0;
      we     = 1'b0;
      cycles = n - 1;
   endtask

   task automatic run_op(input finv_pkg::float_t x, input int tol, input string name);
      logic [31:0] rdata;
      int          n;
      transfer(1'b1, finv_pkg::ADR_OPERAND, x, rdata, n);
      check_cycles({name, " write ack latency"}, n, finv_pkg::PIPE_DEPTH + 1);
      transfer(1'b0, finv_pkg::ADR_RESULT, '0, rdata, n);
      check_float({name, " result"}, rdata, ref_recip(x), tol);
   endtask

   task automatic test_after_reset();
      logic [31:0] rdata;
      int          n;
      check_flag("ack after reset", ack, 1'b0);
      transfer(1'b0, finv_pkg::ADR_RESULT, '0, rdata, n);
      check_cycles("read ack latency", n, 1);
      check_float("result after reset", rdata, '0, 0);
      transfer(1'b0, finv_pkg::ADR_STATUS, '0, rdata, n);
      check_flag("status after reset", rdata[0], 1'b0);
   endtask

   task automatic test_specials();
      finv_pkg::float_t ins [6] = '{32'h00000000, 32'h80000000, 32'h7f800000,
                                    32'hff800000, 32'h7fa00001, 32'hffc00000};
      logic [31:0]      rdata;
      int               n;
      foreach (ins[i]) begin
         run_op(ins[i], 0, $sformatf("special %08h", ins[i]));
         transfer(1'b0, finv_pkg::ADR_STATUS, '0, rdata, n);
         check_flag("status.exception", rdata[0],
                    ins[i].exponent == 8'hff && ins[i].fraction != '0);
      end
   endtask

   task automatic test_pow2();
      finv_pkg::float_t ins [4] = '{32'h3f800000, 32'h40000000, 32'h3f000000, 32'h71800000};
      foreach (ins[i]) begin
         run_op(ins[i], 0, $sformatf("power of two %08h", ins[i]));
      end
   endtask

   task automatic test_denormals();
      finv_pkg::frac_t  fracs [5];
      finv_pkg::float_t x;
      fracs = '{23'h0, 23'h1, 23'h400000, 23'h7fffff, 23'(random_bits(23))};
      for (int e = 253; e <= 254; e++) begin
         foreach (fracs[i]) begin
            x = {i[0], 8'(e), fracs[i]};
            run_op(x, (fracs[i] == '0) ? 0 : 1, $sformatf("denormal result %08h", x));
         end
      end
   endtask

   task automatic test_random();
      finv_pkg::float_t x;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         x.sign     = 1'(random_bits(1));
         // exponents 1 to 252 keep the result normal
         x.exponent = 8'(1 + random_bits(8) % 252);
         x.fraction = 23'(random_bits(23));
         run_op(x, 1, $sformatf("random %08h", x));
      end
   endtask

   task automatic test_bus();
      logic [31:0] rdata;
      int          n;
      run_op(32'h3fc00000, 1, "bus operand 1.5");
      transfer(1'b1, 2'd3, 32'hdeadbeef, rdata, n);
      check_cycles("unmapped write ack latency", n, 1);
      transfer(1'b0, finv_pkg::ADR_RESULT, '0, rdata, n);
      check_cycles("read ack latency", n, 1);
      check_float("result after unmapped write", rdata, ref_recip(32'h3fc00000), 1);
   endtask

   initial begin
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      wait (rst_n === 1'b1);
      @(posedge clk);
      #1;
      test_after_reset();
      test_specials();
      test_pow2();
      test_denormals();
      test_random();
      test_bus();
      $display("SIMULATION PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      report_failure($sformatf("timeout: run did not finish within %0d cycles",
                               WATCHDOG_CYCLES));
   end

endmodule

`default_nettype wire

// File: finv.f
design/finv_pkg.sv
design/finv_operand_if.sv
design/recip_mantissa.sv
design/recip_exponent.sv
design/recip_pack.sv
design/finv_wb.sv
tb/tb_clock.sv
tb/tb_finv.sv

// File: Bender.yml
package:
  name: finv

sources:
  - design/finv_pkg.sv
  - design/finv_operand_if.sv
  - design/recip_mantissa.sv
  - design/recip_exponent.sv
  - design/recip_pack.sv
  - design/finv_wb.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/tb_finv.sv
